// ==== soc_tests.txt ====
// op adr sel dat irq_i gpio_i rsp rd_dat gpio_o gpio_oe_o ibase_o irq_o soft_rst
// op: 0 write, 1 read, 2 set pins and check outputs, f end; rsp: 1 ack, 2 err
0 0010 f 11223344 00 00 1 00000000 00 00 00 0 0
0 0010 1 000000aa 00 00 1 00000000 00 00 00 0 0
0 0010 4 00550000 00 00 1 00000000 00 00 00 0 0
1 0010 f 00000000 00 00 1 115533aa 00 00 00 0 0
0 0014 f deadbeef 00 00 1 00000000 00 00 00 0 0
0 0014 c 12340000 00 00 1 00000000 00 00 00 0 0
1 0014 f 00000000 00 00 1 1234beef 00 00 00 0 0
0 07fc f cafef00d 00 00 1 00000000 00 00 00 0 0
1 07fc f 00000000 00 00 1 cafef00d 00 00 00 0 0
1 0010 f 00000000 00 00 1 115533aa 00 00 00 0 0
0 1100 1 0000005a 00 00 1 00000000 00 00 00 0 0
0 1100 2 0000f000 00 00 1 00000000 00 00 00 0 0
0 1100 8 7e000000 00 00 1 00000000 00 00 00 0 0
2 0000 0 00000000 00 00 0 00000000 5a f0 7e 0 0
1 1100 1 00000000 00 00 1 0000005a 00 00 00 0 0
1 1100 2 00000000 00 00 1 0000f000 00 00 00 0 0
2 0000 0 00000000 00 3c 0 00000000 5a f0 7e 0 0
1 1102 1 00000000 00 3c 1 0000003c 00 00 00 0 0
1 1100 4 00000000 00 3c 1 003c0000 00 00 00 0 0
1 1103 1 00000000 00 3c 1 0000007e 00 00 00 0 0
0 1104 1 000000a5 00 3c 1 00000000 00 00 00 0 1
0 1104 1 0000005a 00 3c 1 00000000 00 00 00 0 0
0 1101 8 a5000000 00 3c 1 00000000 00 00 00 0 1
2 0000 0 00000000 05 3c 0 00000000 5a f0 7e 0 0
1 1000 1 00000000 05 3c 1 00000005 00 00 00 0 0
0 1002 1 00000002 05 3c 1 00000000 00 00 00 0 0
2 0000 0 00000000 05 3c 0 00000000 5a f0 7e 0 0
0 1002 1 00000004 05 3c 1 00000000 00 00 00 0 0
2 0000 0 00000000 05 3c 0 00000000 5a f0 7e 1 0
2 0000 0 00000000 00 3c 0 00000000 5a f0 7e 1 0
0 1000 1 00000004 00 3c 1 00000000 00 00 00 0 0
2 0000 0 00000000 00 3c 0 00000000 5a f0 7e 0 0
1 1000 1 00000000 00 3c 1 00000001 00 00 00 0 0
1 1000 4 00000000 00 3c 1 00040000 00 00 00 0 0
1 2000 f 00000000 00 3c 2 00000000 00 00 00 0 0
0 1100 3 0000ffff 00 3c 2 00000000 00 00 00 0 0
2 0000 0 00000000 00 3c 0 00000000 5a f0 7e 0 0
1 1001 1 00000000 00 3c 1 00000001 00 00 00 0 0
0 1003 1 00000001 00 3c 1 00000000 00 00 00 0 0
2 0000 0 00000000 00 3c 0 00000000 5a f0 7e 2 0
0 1001 1 00000001 00 3c 1 00000000 00 00 00 0 0
2 0000 0 00000000 00 3c 0 00000000 5a f0 7e 0 0
f 0000 0 00000000 00 00 0 00000000 00 00 00 0 0

// ==== verilog.f ====
+incdir+.
soc_pkg.sv
bus_decoder.sv
data_ram.sv
byte_lane_sizer.sv
irq_controller.sv
gpio_regs.sv
soc_bus_top.sv
tb_soc.sv

// ==== Makefile ====
TOP = tb_soc

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f *.sv soc_settings.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP) -j 0

run: compile
	obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_soc.sv ====
`include "soc_settings.svh"

module tb_soc;
    timeunit 1ns;
    timeprecision 100ps;

    import soc_pkg::*;

    localparam int RSP_TIMEOUT = 20;
    localparam int FIELDS      = 13;
    localparam int MAX_TESTS   = 64;

    logic               clk;
    logic               arst_n;
    wb_req_t            bus_req;
    wb_rsp_t            bus_rsp;
    logic [7:0]         irq_pins;
    logic [`GPIO_W-1:0] gpio_in;
    logic [`GPIO_W-1:0] gpio_out;
    logic [`GPIO_W-1:0] gpio_oe;
    logic [7:0]         ibase;
    logic               soft_rst;
    logic [1:0]         irq_out;

    // Test vectors with FIELDS words per test
    logic [31:0] vectors [FIELDS*MAX_TESTS];
    int          errors;
    int          tests;
    int          cur_test;

    soc_bus_top UUT (
        .wb_clk_i   ( clk      ),
        .arst_n_i   ( arst_n   ),
        .bus_req_i  ( bus_req  ),
        .bus_rsp_o  ( bus_rsp  ),
        .irq_i      ( irq_pins ),
        .gpio_i     ( gpio_in  ),
        .gpio_o     ( gpio_out ),
        .gpio_oe_o  ( gpio_oe  ),
        .ibase_o    ( ibase    ),
        .soft_rst_o ( soft_rst ),
        .irq_o      ( irq_out  )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] test %0d: %s got 0x%h, expected 0x%h", cur_test, name, got, exp);
        errors++;
    endtask

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h0:    return "write";
            4'h1:    return "read ";
            4'h2:    return "pins ";
            default: return "???  ";
        endcase
    endfunction

    // Single bus cycle that returns at the falling edge where ack or err shows
    task automatic bus_access(input logic we, input logic [`SOC_ADDR_W-1:0] adr,
                              input logic [`SOC_SEL_W-1:0] sel,
                              input logic [`SOC_DATA_W-1:0] dat,
                              output wb_rsp_t rsp, output logic got_rsp,
                              output int rsp_cycles);
        got_rsp     = 1'b0;
        rsp         = '0;
        rsp_cycles  = 0;
        bus_req.adr = adr;
        bus_req.we  = we;
        bus_req.sel = sel;
        bus_req.dat = dat;
        bus_req.cyc = 1'b1;
        bus_req.stb = 1'b1;
        for (int i = 0; i < RSP_TIMEOUT && !got_rsp; i++) begin
            @(negedge clk);
            rsp_cycles++;
            if (bus_rsp.ack || bus_rsp.err) begin
                got_rsp = 1'b1;
                rsp     = bus_rsp;
            end
        end
        // Strobe drops once the response is seen
        bus_req.cyc = 1'b0;
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
    endtask

    task automatic run_test(input int base);
        logic [3:0]             op;
        logic [`SOC_ADDR_W-1:0] adr;
        logic [`SOC_SEL_W-1:0]  sel;
        logic [`SOC_DATA_W-1:0] dat;
        logic [7:0]             irq;
        logic [`GPIO_W-1:0]     gpio;
        logic [1:0]             exp_rsp;
        logic [`SOC_DATA_W-1:0] exp_dat;
        logic [`GPIO_W-1:0]     exp_gpo;
        logic [`GPIO_W-1:0]     exp_oe;
        logic [7:0]             exp_ib;
        logic [1:0]             exp_irq;
        logic                   exp_rst;
        wb_rsp_t                rsp;
        logic                   got_rsp;
        int                     rsp_cycles;
        logic [2:0]             rst_seen;
        int                     errors_before;

        op      = vectors[base][3:0];
        adr     = vectors[base + 1][`SOC_ADDR_W-1:0];
        sel     = vectors[base + 2][`SOC_SEL_W-1:0];
        dat     = vectors[base + 3];
        irq     = vectors[base + 4][7:0];
        gpio    = vectors[base + 5][`GPIO_W-1:0];
        exp_rsp = vectors[base + 6][1:0];
        exp_dat = vectors[base + 7];
        exp_gpo = vectors[base + 8][`GPIO_W-1:0];
        exp_oe  = vectors[base + 9][`GPIO_W-1:0];
        exp_ib  = vectors[base + 10][7:0];
        exp_irq = vectors[base + 11][1:0];
        exp_rst = vectors[base + 12][0];

        errors_before = errors;
        irq_pins      = irq;
        gpio_in       = gpio;

        case (op)
            4'h0, 4'h1: begin
                bus_access(op == 4'h0, adr, sel, dat, rsp, got_rsp, rsp_cycles);
                if (!got_rsp) begin
                    $display("test %0d: no ack or err within %0d cycles", cur_test, RSP_TIMEOUT);
                    errors++;
                end else begin
                    // Registered response shows one cycle after the strobe is sampled
                    if (rsp_cycles != 1) begin
                        $display("test %0d: response came after %0d cycles instead of 1",
                                 cur_test, rsp_cycles);
                        errors++;
                    end
                    if (rsp.ack !== exp_rsp[0]) begin
                        report_mismatch("bus_rsp_o.ack", 32'(rsp.ack), 32'(exp_rsp[0]));
                    end
                    if (rsp.err !== exp_rsp[1]) begin
                        report_mismatch("bus_rsp_o.err", 32'(rsp.err), 32'(exp_rsp[1]));
                    end
                    if (op == 4'h1 && exp_rsp[0] && rsp.dat !== exp_dat) begin
                        report_mismatch("bus_rsp_o.dat", rsp.dat, exp_dat);
                    end
                end
                // Ack cycle, the cycle after it, and one more
                rst_seen[0] = soft_rst;
                @(negedge clk);
                rst_seen[1] = soft_rst;
                if (bus_rsp.ack || bus_rsp.err) begin
                    $display("test %0d: response held for more than one cycle", cur_test);
                    errors++;
                end
                @(negedge clk);
                rst_seen[2] = soft_rst;
                if (rst_seen !== {1'b0, exp_rst, 1'b0}) begin
                    report_mismatch("soft_rst_o over 3 cycles from ack",
                                    32'(rst_seen), 32'({1'b0, exp_rst, 1'b0}));
                end
            end
            4'h2: begin
                // Two cycles for the input synchronizer and pending bits
                repeat (2) @(negedge clk);
                if (gpio_out !== exp_gpo) begin
                    report_mismatch("gpio_o", 32'(gpio_out), 32'(exp_gpo));
                end
                if (gpio_oe !== exp_oe) begin
                    report_mismatch("gpio_oe_o", 32'(gpio_oe), 32'(exp_oe));
                end
                if (ibase !== exp_ib) begin
                    report_mismatch("ibase_o", 32'(ibase), 32'(exp_ib));
                end
                if (irq_out !== exp_irq) begin
                    report_mismatch("irq_o", 32'(irq_out), 32'(exp_irq));
                end
            end
            default: begin
                $display("test %0d: unknown operation code %h in the test file", cur_test, op);
                errors++;
            end
        endcase

        $display("test %0d %s adr 0x%h sel %h: %s", cur_test, op_name(op), adr, sel,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int   fd;
        logic done;

        errors   = 0;
        tests    = 0;
        cur_test = 0;
        done     = 1'b0;
        bus_req  = '0;
        irq_pins = '0;
        gpio_in  = '0;
        arst_n   = 1'b0;

        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        if ({bus_rsp.ack, bus_rsp.err, irq_out, soft_rst, gpio_oe, gpio_out, ibase} !== '0) begin
            report_mismatch("{ack,err,irq_o,soft_rst_o,gpio_oe_o,gpio_o,ibase_o} after reset",
                32'({bus_rsp.ack, bus_rsp.err, irq_out, soft_rst, gpio_oe, gpio_out, ibase}),
                32'h0);
        end

        fd = $fopen("soc_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open soc_tests.txt");
            errors++;
        end else begin
            $fclose(fd);
            $readmemh("soc_tests.txt", vectors);
            for (int t = 0; t < MAX_TESTS && !done; t++) begin
                if (vectors[t*FIELDS][3:0] == 4'hF) begin
                    done = 1'b1;
                end else begin
                    cur_test = t + 1;
                    tests++;
                    run_test(t*FIELDS);
                end
            end
            if (!done) begin
                $display("test file has no end marker within %0d tests", MAX_TESTS);
                errors++;
            end
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== soc_bus_top.sv ====
`include "soc_settings.svh"

module soc_bus_top (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,
    input  soc_pkg::wb_req_t     bus_req_i,
    output soc_pkg::wb_rsp_t     bus_rsp_o,
    input  logic [7:0]           irq_i,
    input  logic [`GPIO_W-1:0]   gpio_i,
    output logic [`GPIO_W-1:0]   gpio_o,
    output logic [`GPIO_W-1:0]   gpio_oe_o,
    output logic [7:0]           ibase_o,
    output logic                 soft_rst_o,
    output logic [1:0]           irq_o
);
    import soc_pkg::*;

    wb_req_t                mem_req;
    wb_rsp_t                mem_rsp;
    wb_req_t                reg_req;
    wb_rsp_t                reg_rsp;
    logic                   gpio_sel;
    reg8_req_t              pic_req;
    reg8_req_t              gpio_req;
    logic [7:0]             pic_dat;
    logic [7:0]             gpio_dat;
    logic                   pic_ack;
    logic                   gpio_ack;
    logic                   bad_sel;
    logic [`SOC_DATA_W-1:0] ram_dat;
    logic                   ram_ack;

    // Memory never reports an error
    assign mem_rsp = '{dat: ram_dat, ack: ram_ack, err: 1'b0};

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    bus_decoder u_decoder (
        .wb_clk_i   ( wb_clk_i  ),
        .arst_n_i   ( arst_n_i  ),
        .req_i      ( bus_req_i ),
        .rsp_o      ( bus_rsp_o ),
        .mem_req_o  ( mem_req   ),
        .mem_rsp_i  ( mem_rsp   ),
        .reg_req_o  ( reg_req   ),
        .reg_rsp_i  ( reg_rsp   ),
        .gpio_sel_o ( gpio_sel  )
    );

    data_ram u_dmem (
        .wb_clk_i ( wb_clk_i                    ),
        .arst_n_i ( arst_n_i                    ),
        .stb_i    ( mem_req.stb                 ),
        .we_i     ( mem_req.we                  ),
        .sel_i    ( mem_req.sel                 ),
        .adr_i    ( mem_req.adr[`DMEM_AW+1:2]   ),
        .dat_i    ( mem_req.dat                 ),
        .dat_o    ( ram_dat                     ),
        .ack_o    ( ram_ack                     )
    );

    // ----------------------------------------
    // 8-bit register slaves
    // ----------------------------------------
    byte_lane_sizer u_sizer (
        .req_i      ( reg_req  ),
        .rsp_o      ( reg_rsp  ),
        .gpio_sel_i ( gpio_sel ),
        .pic_req_o  ( pic_req  ),
        .gpio_req_o ( gpio_req ),
        .pic_dat_i  ( pic_dat  ),
        .gpio_dat_i ( gpio_dat ),
        .pic_ack_i  ( pic_ack  ),
        .gpio_ack_i ( gpio_ack ),
        .bad_sel_o  ( bad_sel  )
    );

    // Sources 0-7 external, 8 bad select, rest tied low
    irq_controller u_pic (
        .wb_clk_i ( wb_clk_i                                    ),
        .arst_n_i ( arst_n_i                                    ),
        .req_i    ( pic_req                                     ),
        .dat_o    ( pic_dat                                     ),
        .ack_o    ( pic_ack                                     ),
        .src_i    ( {{(`IRQ_SOURCES-9){1'b0}}, bad_sel, irq_i}  ),
        .irq_o    ( irq_o                                       )
    );

    gpio_regs u_gpio (
        .wb_clk_i   ( wb_clk_i   ),
        .arst_n_i   ( arst_n_i   ),
        .req_i      ( gpio_req   ),
        .dat_o      ( gpio_dat   ),
        .ack_o      ( gpio_ack   ),
        .gpio_i     ( gpio_i     ),
        .gpio_o     ( gpio_o     ),
        .gpio_oe_o  ( gpio_oe_o  ),
        .ibase_o    ( ibase_o    ),
        .soft_rst_o ( soft_rst_o )
    );

endmodule

// ==== gpio_regs.sv ====
`include "soc_settings.svh"

module gpio_regs (
    input  logic               wb_clk_i,
    input  logic               arst_n_i,
    input  soc_pkg::reg8_req_t req_i,
    output logic [7:0]         dat_o,
    output logic               ack_o,
    input  logic [`GPIO_W-1:0] gpio_i,
    output logic [`GPIO_W-1:0] gpio_o,
    output logic [`GPIO_W-1:0] gpio_oe_o,
    output logic [7:0]         ibase_o,
    output logic               soft_rst_o
);
    import soc_pkg::*;

    logic [`GPIO_W-1:0] gpio_meta;
    logic [`GPIO_W-1:0] gpio_sync;
    logic               wr_en;
    logic               key_wr_q;

    assign wr_en = req_i.stb & req_i.we & ~ack_o;

    // ----------------------------------------
    // Control registers
    // ----------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o      <= 1'b0;
            gpio_o     <= '0;
            gpio_oe_o  <= '0;
            ibase_o    <= '0;
            key_wr_q   <= 1'b0;
            soft_rst_o <= 1'b0;
        end else begin
            ack_o <= req_i.stb & ~ack_o;
            if (wr_en) begin
                case (req_i.offset)
                    8'd0:    gpio_o    <= req_i.dat[`GPIO_W-1:0];
                    8'd1:    gpio_oe_o <= req_i.dat[`GPIO_W-1:0];
                    8'd3:    ibase_o   <= req_i.dat;
                    default: ;
                endcase
            end
            // Pulse goes out the cycle after the key write is acked
            key_wr_q   <= wr_en && req_i.offset == 8'd4 && req_i.dat == `SOFT_RST_KEY;
            soft_rst_o <= key_wr_q;
        end
    end

    // Two flop synchronizer on the pins
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_meta <= '0;
            gpio_sync <= '0;
        end else begin
            gpio_meta <= gpio_i;
            gpio_sync <= gpio_meta;
        end
    end

    always_comb begin
        case (req_i.offset)
            8'd0:    dat_o = gpio_o;
            8'd1:    dat_o = gpio_oe_o;
            8'd2:    dat_o = gpio_sync;
            8'd3:    dat_o = ibase_o;
            default: dat_o = 8'h00;
        endcase
    end

    // The ack interlock keeps each key write to a single pulse
    soft_rst_single: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        soft_rst_o |=> !soft_rst_o
    ) else $error("gpio_regs: soft reset pulse longer than one cycle");

endmodule

// ==== irq_controller.sv ====
`include "soc_settings.svh"

module irq_controller (
    input  logic                    wb_clk_i,
    input  logic                    arst_n_i,
    input  soc_pkg::reg8_req_t      req_i,
    output logic [7:0]              dat_o,
    output logic                    ack_o,
    input  logic [`IRQ_SOURCES-1:0] src_i,
    output logic [1:0]              irq_o
);
    import soc_pkg::*;

    logic [`IRQ_SOURCES-1:0] pending_q;
    logic [`IRQ_SOURCES-1:0] enable_q;
    logic [`IRQ_SOURCES-1:0] clr;
    logic                    wr_en;

    assign wr_en = req_i.stb & req_i.we & ~ack_o;

    // Write 1 to clear on the pending bytes
    always_comb begin
        clr = '0;
        if (wr_en) begin
            case (req_i.offset)
                8'd0:    clr[7:0]  = req_i.dat;
                8'd1:    clr[15:8] = req_i.dat;
                default: clr       = '0;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            enable_q  <= '0;
            ack_o     <= 1'b0;
        end else begin
            ack_o <= req_i.stb & ~ack_o;
            // A live source wins over a clear
            pending_q <= (pending_q & ~clr) | src_i;
            if (wr_en && req_i.offset == 8'd2) begin
                enable_q[7:0] <= req_i.dat;
            end
            if (wr_en && req_i.offset == 8'd3) begin
                enable_q[15:8] <= req_i.dat;
            end
        end
    end

    always_comb begin
        case (req_i.offset)
            8'd0:    dat_o = pending_q[7:0];
            8'd1:    dat_o = pending_q[15:8];
            8'd2:    dat_o = enable_q[7:0];
            8'd3:    dat_o = enable_q[15:8];
            default: dat_o = 8'h00;
        endcase
    end

    // One output per byte group
    assign irq_o[0] = |(pending_q[7:0] & enable_q[7:0]);
    assign irq_o[1] = |(pending_q[15:8] & enable_q[15:8]);

endmodule

// ==== byte_lane_sizer.sv ====
`include "soc_settings.svh"

module byte_lane_sizer (
    input  soc_pkg::wb_req_t   req_i,
    output soc_pkg::wb_rsp_t   rsp_o,
    input  logic               gpio_sel_i,
    output soc_pkg::reg8_req_t pic_req_o,
    output soc_pkg::reg8_req_t gpio_req_o,
    input  logic [7:0]         pic_dat_i,
    input  logic [7:0]         gpio_dat_i,
    input  logic               pic_ack_i,
    input  logic               gpio_ack_i,
    output logic               bad_sel_o
);
    import soc_pkg::*;

    bus_word_u  wr_word;
    bus_word_u  rd_word;
    reg8_req_t  req8;
    logic [1:0] lane;
    logic       bad_sel;
    logic [7:0] rd_byte;
    logic       slv_ack;

    // Exactly one byte lane must be selected
    always_comb begin
        bad_sel = 1'b0;
        case (req_i.sel)
            4'b0001: lane = 2'd0;
            4'b0010: lane = 2'd1;
            4'b0100: lane = 2'd2;
            4'b1000: lane = 2'd3;
            default: begin
                lane    = 2'd0;
                bad_sel = 1'b1;
            end
        endcase
    end

    assign wr_word.word = req_i.dat;

    // Bad select still runs a harmless read so err keeps the slave timing
    always_comb begin
        req8.offset = req_i.adr[7:0] + {6'd0, lane};
        req8.we     = req_i.we & ~bad_sel;
        req8.dat    = wr_word.bytes[lane];
        req8.stb    = req_i.cyc & req_i.stb;

        pic_req_o      = req8;
        pic_req_o.stb  = req8.stb & ~gpio_sel_i;
        gpio_req_o     = req8;
        gpio_req_o.stb = req8.stb & gpio_sel_i;
    end

    assign rd_byte = gpio_sel_i ? gpio_dat_i : pic_dat_i;
    assign slv_ack = gpio_sel_i ? gpio_ack_i : pic_ack_i;

    // ----------------------------------------
    // Read byte back onto its own lane
    // ----------------------------------------
    always_comb begin
        rd_word.word        = '0;
        rd_word.bytes[lane] = rd_byte;

        rsp_o.dat = rd_word.word;
        rsp_o.ack = slv_ack & ~bad_sel;
        rsp_o.err = slv_ack & bad_sel;
    end

    assign bad_sel_o = rsp_o.err;

endmodule

// ==== data_ram.sv ====
`include "soc_settings.svh"

module data_ram (
    input  logic                   wb_clk_i,
    input  logic                   arst_n_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  logic [`SOC_SEL_W-1:0]  sel_i,
    input  logic [`DMEM_AW-1:0]    adr_i,
    input  logic [`SOC_DATA_W-1:0] dat_i,
    output logic [`SOC_DATA_W-1:0] dat_o,
    output logic                   ack_o
);

    logic [`SOC_DATA_W-1:0] mem [2**`DMEM_AW];
    logic                   access;

    // One access per strobe and none while ack is high
    assign access = stb_i & ~ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            for (int i = 0; i < `SOC_SEL_W; i++) begin
                if (we_i && sel_i[i]) begin
                    mem[adr_i][i*8 +: 8] <= dat_i[i*8 +: 8];
                end
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    // A strobe still high after the ack would start a second access
    stb_low_after_ack: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        ack_o |=> !stb_i
    ) else $error("data_ram: strobe still high the cycle after ack");

endmodule

// ==== bus_decoder.sv ====
`include "soc_settings.svh"

module bus_decoder (
    input  logic             wb_clk_i,
    input  logic             arst_n_i,
    input  soc_pkg::wb_req_t req_i,
    output soc_pkg::wb_rsp_t rsp_o,
    output soc_pkg::wb_req_t mem_req_o,
    input  soc_pkg::wb_rsp_t mem_rsp_i,
    output soc_pkg::wb_req_t reg_req_o,
    input  soc_pkg::wb_rsp_t reg_rsp_i,
    output logic             gpio_sel_o
);
    import soc_pkg::*;

    localparam logic [`SOC_ADDR_W-1:0] DMEM_BASE_A = `DMEM_BASE;
    localparam logic [`SOC_ADDR_W-1:0] PIC_BASE_A  = `PIC_BASE;
    localparam logic [`SOC_ADDR_W-1:0] GPIO_BASE_A = `GPIO_BASE;
    localparam int MEM_LSB = `DMEM_AW + 2;
    localparam int WIN_LSB = 8;

    logic req_act;
    logic mem_hit;
    logic pic_hit;
    logic gpio_hit;
    logic reg_hit;
    logic err_q;

    assign req_act  = req_i.cyc & req_i.stb;
    assign mem_hit  = req_i.adr[`SOC_ADDR_W-1:MEM_LSB] == DMEM_BASE_A[`SOC_ADDR_W-1:MEM_LSB];
    assign pic_hit  = req_i.adr[`SOC_ADDR_W-1:WIN_LSB] == PIC_BASE_A[`SOC_ADDR_W-1:WIN_LSB];
    assign gpio_hit = req_i.adr[`SOC_ADDR_W-1:WIN_LSB] == GPIO_BASE_A[`SOC_ADDR_W-1:WIN_LSB];
    assign reg_hit  = pic_hit | gpio_hit;

    assign gpio_sel_o = gpio_hit;

    // Forward the request with the strobe gated per region
    always_comb begin
        mem_req_o     = req_i;
        mem_req_o.stb = req_act & mem_hit;
        reg_req_o     = req_i;
        reg_req_o.stb = req_act & reg_hit;
    end

    // Unmapped addresses are answered here
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_act & ~mem_hit & ~reg_hit & ~err_q;
        end
    end

    always_comb begin
        if (mem_hit) begin
            rsp_o = mem_rsp_i;
        end else if (reg_hit) begin
            rsp_o = reg_rsp_i;
        end else begin
            rsp_o     = '0;
            rsp_o.err = err_q;
        end
    end

    mem_reg_exclusive: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        !(mem_req_o.stb && reg_req_o.stb)
    ) else $error("bus_decoder: memory and register strobes both active");

endmodule

// ==== soc_pkg.sv ====
`include "soc_settings.svh"

package soc_pkg;

    // Wishbone request from the master side
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] adr;
        logic                   we;
        logic [`SOC_SEL_W-1:0]  sel;
        logic [`SOC_DATA_W-1:0] dat;
        logic                   cyc;
        logic                   stb;
    } wb_req_t;

    // Wishbone response back to the master
    typedef struct packed {
        logic [`SOC_DATA_W-1:0] dat;
        logic                   ack;
        logic                   err;
    } wb_rsp_t;

    // Single byte access to an 8-bit register block
    typedef struct packed {
        logic [7:0] offset;
        logic       we;
        logic [7:0] dat;
        logic       stb;
    } reg8_req_t;

    // Bus word seen whole or as byte lanes
    typedef union packed {
        logic [`SOC_DATA_W-1:0]     word;
        logic [`SOC_SEL_W-1:0][7:0] bytes;
    } bus_word_u;

endpackage

// ==== soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_ADDR_W   16
`define SOC_DATA_W   32
`define SOC_SEL_W    4

// Data memory of 512 words
`define DMEM_AW      9

// Peripheral sizes
`define IRQ_SOURCES  16
`define GPIO_W       8

// Address map
`define DMEM_BASE    16'h0000
`define PIC_BASE     16'h1000
`define GPIO_BASE    16'h1100

// Value that triggers the soft reset pulse
`define SOFT_RST_KEY 8'hA5

`endif
